//--- source/sd_link_pkg.sv
`default_nettype none

// ----------------------------------------
// shared widths, limits and types for the
// srdy/drdy link self-test
// ----------------------------------------

package sd_link_pkg;

  // width of every count in the subsystem
  // word count, error count, cycle count, run length
  parameter int cnt_width = 16;

  // idle cycles at the checker before a run is declared stuck
  // must fit in cnt_width bits
  parameter int stall_limit = 64;

  // ----------------------------------------
  // run controller states
  // ----------------------------------------
  // s_idle    waiting for start
  // s_run     generator enabled, words flowing
  // s_drain   one settling cycle after the last word
  // s_report  done strobe, pass result valid
  typedef enum logic [1:0]
  {
    s_idle   = 2'd0,
    s_run    = 2'd1,
    s_drain  = 2'd2,
    s_report = 2'd3
  } run_state_t;

endpackage

`default_nettype wire

//--- source/sd_seq_gen.sv
`default_nettype none
`timescale 1ns/1ps

module sd_seq_gen
  #(parameter int width = 8)
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  logic                              enable,
    input  logic [width-1:0]                  start_value,
    input  logic [sd_link_pkg::cnt_width-1:0] run_len,
    input  logic [sd_link_pkg::cnt_width-1:0] corrupt_index,
    input  logic [7:0]                        src_pattern,
    output logic                              srdy,
    input  logic                              drdy,
    output logic [width-1:0]                  data
  );
  import sd_link_pkg::*;

  logic [width-1:0]     seq;
  logic [cnt_width-1:0] sent;
  logic [cnt_width:0]   word_num;
  logic [7:0]           pat;
  logic                 hs;
  logic                 more;
  logic                 bad_word;

  assign hs = srdy & drdy;

  // 1-based number of the word now on offer
  assign word_num = {1'b0, sent} + 1'b1;

  // words still owed once this cycle is over
  assign more = hs ? (word_num < {1'b0, run_len}) : (sent < run_len);

  // flip bit 0 of the one chosen word
  assign bad_word = (word_num == {1'b0, corrupt_index});
  assign data = seq ^ {{(width-1){1'b0}}, bad_word};

  // ----------------------------------------
  // srdy throttle and word count
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      srdy <= 1'b0;
      sent <= '0;
      pat  <= '0;
    end
    else if (clear)
    begin
      srdy <= 1'b0;
      sent <= '0;
      pat  <= src_pattern;
    end
    else
    begin
      if (hs)
        sent <= sent + 1'b1;
      // offered word is held until taken
      if (!srdy || hs)
      begin
        srdy <= enable & pat[0] & more;
        pat  <= {pat[6:0], pat[7]};
      end
    end
  end

  // sequence value, loaded at clear
  always_ff @(posedge clk)
  begin
    if (clear)
      seq <= start_value;
    else if (hs)
      seq <= seq + 1'b1;
  end

  // word on offer must not change under back-pressure
  assert property (@(posedge clk) disable iff (reset || clear)
    (srdy && !drdy) |=> (srdy && $stable(data)));

endmodule

`default_nettype wire

//--- source/sd_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module sd_fifo
  #(
    parameter int width = 8,
    parameter int depth = 4
  )
  (
    input  logic             clk,
    input  logic             reset,
    input  logic             clear,
    input  logic             c_srdy,
    output logic             c_drdy,
    input  logic [width-1:0] c_data,
    output logic             p_srdy,
    input  logic             p_drdy,
    output logic [width-1:0] p_data
  );

  // depth is a power of two, at least 2
  localparam int aw = $clog2(depth);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [aw:0]      count;
  logic [aw:0]      count_next;
  logic             wr_en;
  logic             rd_en;

  assign wr_en  = c_srdy & c_drdy;
  assign rd_en  = p_srdy & p_drdy;
  assign p_srdy = (count != '0);
  assign p_data = mem[rd_ptr];

  // occupancy after this cycle
  always_comb
  begin
    case ({wr_en, rd_en})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // ----------------------------------------
  // pointers, count, registered c_drdy
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      c_drdy <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      count  <= count_next;
      // room for one more next cycle
      c_drdy <= (count_next != (aw+1)'(depth));
    end
  end

  // storage, pointers wrap on their own
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= c_data;
  end

  assert property (@(posedge clk) disable iff (reset || clear)
    wr_en |-> (count < (aw+1)'(depth)));

  // read only with a stored word, seen from the pointers
  assert property (@(posedge clk) disable iff (reset || clear)
    rd_en |-> (wr_ptr != rd_ptr || count == (aw+1)'(depth)));

endmodule

`default_nettype wire

//--- source/sd_seq_check.sv
`default_nettype none
`timescale 1ns/1ps

module sd_seq_check
  #(parameter int width = 8)
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  logic [width-1:0]                  start_value,
    input  logic [7:0]                        dst_pattern,
    input  logic                              srdy,
    output logic                              drdy,
    input  logic [width-1:0]                  data,
    output logic                              xfer,
    output logic [sd_link_pkg::cnt_width-1:0] word_count,
    output logic [sd_link_pkg::cnt_width-1:0] err_count
  );

  logic [width-1:0] expected;
  logic [7:0]       pat;
  logic             miss;

  // one pulse per accepted word
  assign xfer = srdy & drdy;
  assign miss = (data != expected);

  // ----------------------------------------
  // drdy throttle
  // ----------------------------------------
  // pattern steps while drdy is low or a word is taken
  // pattern is zero out of reset, so drdy stays low until clear
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      drdy <= 1'b0;
      pat  <= '0;
    end
    else if (clear)
    begin
      drdy <= 1'b0;
      pat  <= dst_pattern;
    end
    else if (xfer || !drdy)
    begin
      drdy <= pat[0];
      pat  <= {pat[6:0], pat[7]};
    end
  end

  // ----------------------------------------
  // word and error counts, saturating
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      word_count <= '0;
      err_count  <= '0;
    end
    else if (xfer)
    begin
      if (word_count != '1)
        word_count <= word_count + 1'b1;
      if (miss && err_count != '1)
        err_count <= err_count + 1'b1;
    end
  end

  // expected value moves on every taken word, match or not
  // so one bad word costs exactly one error
  always_ff @(posedge clk)
  begin
    if (clear)
      expected <= start_value;
    else if (xfer)
      expected <= expected + 1'b1;
  end

endmodule

`default_nettype wire

//--- source/sd_run_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module sd_run_ctrl
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [sd_link_pkg::cnt_width-1:0] run_len,
    input  logic [sd_link_pkg::cnt_width-1:0] word_count,
    input  logic [sd_link_pkg::cnt_width-1:0] err_count,
    input  logic                              stalled,
    output logic                              run_clear,
    output logic                              gen_enable,
    output logic                              busy,
    output logic                              done,
    output logic                              pass
  );
  import sd_link_pkg::*;

  run_state_t state;
  run_state_t state_next;
  logic       all_words;
  logic       pass_cond;

  assign all_words = (word_count == run_len);
  assign pass_cond = (err_count == '0) && !stalled && all_words;

  // start only counts from idle
  assign run_clear  = start && (state == s_idle);
  assign gen_enable = (state == s_run);
  assign busy       = (state != s_idle);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      s_idle:
        if (start)
          state_next = s_run;
      s_run:
        if (all_words)
          state_next = s_drain;
        else if (stalled)
          state_next = s_report;
      s_drain:
        state_next = s_report;
      s_report:
        state_next = s_idle;
      default:
        state_next = s_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= s_idle;
      done  <= 1'b0;
      pass  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      done  <= (state_next == s_report);
      // result held from done until the next start
      if (run_clear)
        pass <= 1'b0;
      else if (state_next == s_report)
        pass <= pass_cond;
    end
  end

  // done only in report, after every word or a stall
  assert property (@(posedge clk) disable iff (reset)
    done |-> (state == s_report && (all_words || stalled)));

  // clear has to reach the checker counts in one cycle
  assert property (@(posedge clk) disable iff (reset)
    run_clear |=> (word_count == '0 && err_count == '0));

endmodule

`default_nettype wire

//--- source/sd_cycle_timer.sv
`default_nettype none
`timescale 1ns/1ps

module sd_cycle_timer
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  logic                              busy,
    input  logic                              xfer,
    output logic                              stalled,
    output logic [sd_link_pkg::cnt_width-1:0] cycle_count
  );
  import sd_link_pkg::*;

  logic [cnt_width-1:0] idle_count;
  logic [cnt_width-1:0] idle_next;

  // idle run length, parks at the limit
  always_comb
  begin
    if (xfer || !busy)
      idle_next = '0;
    else if (idle_count == cnt_width'(stall_limit))
      idle_next = idle_count;
    else
      idle_next = idle_count + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      cycle_count <= '0;
      idle_count  <= '0;
      stalled     <= 1'b0;
    end
    else
    begin
      if (busy && cycle_count != '1)
        cycle_count <= cycle_count + 1'b1;
      idle_count <= idle_next;
      // sticky until the next clear
      if (busy && idle_next == cnt_width'(stall_limit))
        stalled <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/sd_link_test.sv
`default_nettype none
`timescale 1ns/1ps

module sd_link_test
  #(
    parameter int width = 8,
    parameter int depth = 4
  )
  (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [sd_link_pkg::cnt_width-1:0] run_len,
    input  logic [width-1:0]                  start_value,
    input  logic [7:0]                        src_pattern,
    input  logic [7:0]                        dst_pattern,
    input  logic [sd_link_pkg::cnt_width-1:0] corrupt_index,
    output logic                              busy,
    output logic                              done,
    output logic                              pass,
    output logic                              stalled,
    output logic [sd_link_pkg::cnt_width-1:0] word_count,
    output logic [sd_link_pkg::cnt_width-1:0] err_count,
    output logic [sd_link_pkg::cnt_width-1:0] cycle_count
  );

  // ----------------------------------------
  // control
  // ----------------------------------------
  logic run_clear;
  logic gen_enable;
  logic xfer;

  // generator to fifo
  logic             gen_srdy;
  logic             gen_drdy;
  logic [width-1:0] gen_data;

  // fifo to checker
  logic             chk_srdy;
  logic             chk_drdy;
  logic [width-1:0] chk_data;

  sd_run_ctrl ctrl_i
  (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .run_len    (run_len),
    .word_count (word_count),
    .err_count  (err_count),
    .stalled    (stalled),
    .run_clear  (run_clear),
    .gen_enable (gen_enable),
    .busy       (busy),
    .done       (done),
    .pass       (pass)
  );

  sd_cycle_timer timer_i
  (
    .clk         (clk),
    .reset       (reset),
    .clear       (run_clear),
    .busy        (busy),
    .xfer        (xfer),
    .stalled     (stalled),
    .cycle_count (cycle_count)
  );

  // ----------------------------------------
  // data path, gen -> fifo -> check
  // ----------------------------------------
  sd_seq_gen #(.width(width)) gen_i
  (
    .clk           (clk),
    .reset         (reset),
    .clear         (run_clear),
    .enable        (gen_enable),
    .start_value   (start_value),
    .run_len       (run_len),
    .corrupt_index (corrupt_index),
    .src_pattern   (src_pattern),
    .srdy          (gen_srdy),
    .drdy          (gen_drdy),
    .data          (gen_data)
  );

  // link under test
  sd_fifo #(.width(width), .depth(depth)) fifo_i
  (
    .clk    (clk),
    .reset  (reset),
    .clear  (run_clear),
    .c_srdy (gen_srdy),
    .c_drdy (gen_drdy),
    .c_data (gen_data),
    .p_srdy (chk_srdy),
    .p_drdy (chk_drdy),
    .p_data (chk_data)
  );

  sd_seq_check #(.width(width)) check_i
  (
    .clk         (clk),
    .reset       (reset),
    .clear       (run_clear),
    .start_value (start_value),
    .dst_pattern (dst_pattern),
    .srdy        (chk_srdy),
    .drdy        (chk_drdy),
    .data        (chk_data),
    .xfer        (xfer),
    .word_count  (word_count),
    .err_count   (err_count)
  );

endmodule

`default_nettype wire

//--- bench/sd_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

// free-running testbench clock
module sd_clock_gen
  #(parameter real period = 20.0)
  (
    output logic clk
  );

  initial
  begin
    clk = 1'b0;
  end

  // half period high, half period low
  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- bench/sd_link_test_tb.sv
`default_nettype none
`timescale 1ns/1ps

module sd_link_test_tb;
  import sd_link_pkg::*;

  localparam int width    = 8;
  localparam int depth    = 4;
  localparam int max_rows = 16;

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic [cnt_width-1:0] run_len;
  logic [width-1:0]     start_value;
  logic [7:0]           src_pattern;
  logic [7:0]           dst_pattern;
  logic [cnt_width-1:0] corrupt_index;
  logic                 busy;
  logic                 done;
  logic                 pass;
  logic                 stalled;
  logic [cnt_width-1:0] word_count;
  logic [cnt_width-1:0] err_count;
  logic [cnt_width-1:0] cycle_count;

  // ----------------------------------------
  // test table, stimulus and expected values
  // ----------------------------------------
  logic [cnt_width-1:0] t_len     [max_rows];
  logic [width-1:0]     t_start   [max_rows];
  logic [7:0]           t_src     [max_rows];
  logic [7:0]           t_dst     [max_rows];
  logic [cnt_width-1:0] t_corrupt [max_rows];
  logic [cnt_width-1:0] t_words   [max_rows];
  logic [cnt_width-1:0] t_errs    [max_rows];
  logic                 t_pass    [max_rows];
  logic                 t_stall   [max_rows];

  int n_rows       = 0;
  int seed         = 45290;
  int test_errs    = 0;
  int pass_count   = 0;
  int fail_count   = 0;
  int limit_cycles = 0;
  bit table_ready  = 1'b0;

  sd_clock_gen #(.period(20.0)) clock_i
  (
    .clk (clk)
  );

  sd_link_test #(.width(width), .depth(depth)) dut_i
  (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .run_len       (run_len),
    .start_value   (start_value),
    .src_pattern   (src_pattern),
    .dst_pattern   (dst_pattern),
    .corrupt_index (corrupt_index),
    .busy          (busy),
    .done          (done),
    .pass          (pass),
    .stalled       (stalled),
    .word_count    (word_count),
    .err_count     (err_count),
    .cycle_count   (cycle_count)
  );

  // expected results follow from the link rules
  // an all-zero pattern on either side means no word ever moves
  task automatic add_row(input int len, input logic [width-1:0] sv,
                         input logic [7:0] src, input logic [7:0] dst, input int corrupt);
    logic stuck;
    logic hit;
    begin
      stuck = (src == 8'h00) || (dst == 8'h00);
      hit   = (corrupt >= 1) && (corrupt <= len);
      t_len[n_rows]     = cnt_width'(len);
      t_start[n_rows]   = sv;
      t_src[n_rows]     = src;
      t_dst[n_rows]     = dst;
      t_corrupt[n_rows] = cnt_width'(corrupt);
      t_stall[n_rows]   = stuck;
      t_words[n_rows]   = stuck ? '0 : cnt_width'(len);
      t_errs[n_rows]    = (!stuck && hit) ? 1 : 0;
      t_pass[n_rows]    = !stuck && !hit;
      n_rows++;
    end
  endtask

  task automatic build_table();
    begin
      add_row(20, 8'h10, 8'hff, 8'hff, 0);
      add_row(40, width'($random(seed)), 8'b10010001, 8'b01000011, 0);
      add_row(30, width'($random(seed)), 8'b01000011, 8'b10010001, 0);
      // slow consumer, fifo fills up
      add_row(24, width'($random(seed)), 8'hff, 8'b00000101, 0);
      add_row(16, 8'h40, 8'hff, 8'hff, 5);
      add_row(16, 8'h40, 8'b10010001, 8'b01000011, 16);
      add_row(16, 8'h40, 8'hff, 8'hff, 17);
      // data wraps past all ones
      add_row(12, 8'hff, 8'hff, 8'hff, 0);
      add_row(12, 8'hff, 8'b10010001, 8'b01000011, 1);
      add_row(10, 8'h00, 8'hff, 8'h00, 0);
      add_row(8, width'($random(seed)), 8'hff, 8'hff, 0);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    begin
      if (actual !== expected)
      begin
        $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        test_errs++;
      end
    end
  endtask

  task automatic close_test(input string label);
    begin
      if (test_errs == 0)
      begin
        pass_count++;
        $display("%s: ok", label);
      end
      else
      begin
        fail_count++;
        $display("%s: %0d check(s) wrong", label, test_errs);
      end
    end
  endtask

  // ----------------------------------------
  // one table row, start to done
  // ----------------------------------------
  task automatic run_row(input int r);
    begin
      test_errs = 0;
      @(negedge clk);
      run_len       = t_len[r];
      start_value   = t_start[r];
      src_pattern   = t_src[r];
      dst_pattern   = t_dst[r];
      corrupt_index = t_corrupt[r];
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      check_value("busy", 1, busy);
      while (done !== 1'b1)
        @(negedge clk);
      check_value("word_count", t_words[r], word_count);
      check_value("err_count", t_errs[r], err_count);
      check_value("pass", t_pass[r], pass);
      check_value("stalled", t_stall[r], stalled);
      if (t_stall[r] && cycle_count < stall_limit)
      begin
        $display("FAILED at %0t ns: cycle_count expected at least %0d, got %0d",
                 $time, stall_limit, cycle_count);
        test_errs++;
      end
      // done is one cycle, pass is held
      @(negedge clk);
      check_value("done", 0, done);
      check_value("busy", 0, busy);
      check_value("pass", t_pass[r], pass);
      close_test($sformatf("test %0d len %0d start %02h src %08b dst %08b corrupt %0d",
                           r, t_len[r], t_start[r], t_src[r], t_dst[r], t_corrupt[r]));
    end
  endtask

  // watchdog, budget grows with run length
  initial
  begin
    wait (table_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    reset         = 1'b1;
    start         = 1'b0;
    run_len       = '0;
    start_value   = '0;
    src_pattern   = '0;
    dst_pattern   = '0;
    corrupt_index = '0;
    build_table();
    limit_cycles = 8 + 20;
    for (int i = 0; i < n_rows; i++)
      limit_cycles += t_len[i] * 8 + 100;
    table_ready = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // idle state right after reset
    test_errs = 0;
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("pass", 0, pass);
    check_value("stalled", 0, stalled);
    check_value("word_count", 0, word_count);
    check_value("err_count", 0, err_count);
    check_value("cycle_count", 0, cycle_count);
    close_test("reset state");

    for (int i = 0; i < n_rows; i++)
      run_row(i);

    $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- sd_link_test.f
source/sd_link_pkg.sv
source/sd_seq_gen.sv
source/sd_fifo.sv
source/sd_seq_check.sv
source/sd_run_ctrl.sv
source/sd_cycle_timer.sv
source/sd_link_test.sv
bench/sd_clock_gen.sv
bench/sd_link_test_tb.sv
